/* sim.f */
verilog/preparser_pkg.sv
verilog/tag_decoder.sv
verilog/beat_slicer.sv
verilog/token_speculator.sv
verilog/token_chainer.sv
verilog/slice_accountant.sv
verilog/preparser.sv
verification/preparser_properties.sv
verification/preparser_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the preparser testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module preparser_tb -f sim.f -o sim_preparser
./obj_dir/sim_preparser | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
grep -q "TESTBENCH PASSED" sim.log

/* verification/preparser_tb.sv */
/*
 * preparser testbench
 * directed streams through the four stage pipeline, checked against a
 * sequential token walk over the stream bytes
 */
`timescale 1ns/1ps

module preparser_tb;

	localparam int TOTAL_BEATS = 1 + 3 + 3 + 3 + 12;	// longest case of each test
	localparam int LIMIT       = TOTAL_BEATS * 10 + 200;

	logic                      clk;
	logic                      rst_n;
	logic                      start;
	preparser_pkg::addr_t      stream_len;
	preparser_pkg::beat_t      data;
	logic                      in_valid;
	logic                      in_ready;
	preparser_pkg::out_slice_t slice_out;
	logic                      out_valid;
	logic                      out_ready;
	logic                      stream_done;

	preparser_pkg::byte_t      stream_q[$];	// stream under test, unpadded
	preparser_pkg::out_slice_t exp_q[$];
	preparser_pkg::out_slice_t got_q[$];	// every slice seen this stream
	int tok_start[$];
	int tok_hdr[$];
	int tok_pay[$];
	int tok_copy[$];	// copy length, -1 for a literal
	int err_cnt;
	int chk_cnt;
	int cycles;
	logic rand_ready;

	preparser dut_i (
		.clk(clk), .rst_n(rst_n), .start(start), .stream_len(stream_len),
		.data(data), .in_valid(in_valid), .in_ready(in_ready),
		.slice_out(slice_out), .out_valid(out_valid), .out_ready(out_ready),
		.stream_done(stream_done)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// compare tasks

	task automatic check_slice(preparser_pkg::out_slice_t got, preparser_pkg::out_slice_t exp);
		chk_cnt++;
		if (got.data !== exp.data) begin
			err_cnt++;
			$display("[FAIL] %0t slice_out.data: got %h expected %h", $time, got.data, exp.data);
		end
		if (got.token_pos !== exp.token_pos) begin
			err_cnt++;
			$display("[FAIL] %0t slice_out.token_pos: got %h expected %h", $time,
				got.token_pos, exp.token_pos);
		end
		if (got.address !== exp.address) begin
			err_cnt++;
			$display("[FAIL] %0t slice_out.address: got %h expected %h", $time,
				got.address, exp.address);
		end
		if (got.start_lit !== exp.start_lit || got.garbage_cnt !== exp.garbage_cnt) begin
			err_cnt++;
			$display("[FAIL] %0t slice_out.start_lit/garbage_cnt: got %b/%0d expected %b/%0d",
				$time, got.start_lit, got.garbage_cnt, exp.start_lit, exp.garbage_cnt);
		end
	endtask

	task automatic check_done(logic got, logic exp, string name);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(preparser_pkg::garbage_t got, preparser_pkg::garbage_t exp,
		string name);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(preparser_pkg::addr_t got, preparser_pkg::addr_t exp, string name);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_mask(preparser_pkg::pos_mask_t got, preparser_pkg::pos_mask_t exp,
		string name);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic need_slices(int n);
		if (got_q.size() < n) begin
			err_cnt++;
			$display("only %0d slices arrived where %0d were needed", got_q.size(), n);
		end
	endtask

	////////////////////////////////////////
	// stream building

	function automatic preparser_pkg::byte_t get_byte(int i);
		return (i < stream_q.size()) ? stream_q[i] : 8'h00;	// padding reads as zero
	endfunction

	// kind 0 inline length, 1 one extra length byte, 2 two extra length bytes
	task automatic add_lit(int n, int kind);
		if (kind == 0)
			stream_q.push_back(8'((n - 1) << 2));
		else if (kind == 1) begin
			stream_q.push_back(8'hf0);
			stream_q.push_back(8'(n - 1));
		end else begin
			stream_q.push_back(8'hf4);
			stream_q.push_back(8'(n - 1));	// low byte first
			stream_q.push_back(8'((n - 1) >> 8));
		end
		repeat (n) stream_q.push_back(8'($urandom));
	endtask

	task automatic add_copy1(int len);	// len 4 to 11
		stream_q.push_back(8'(((len - 4) << 2) | 1));
		stream_q.push_back(8'($urandom % 255 + 1));
	endtask

	task automatic add_copy2(int len);	// len 1 to 64
		stream_q.push_back(8'(((len - 1) << 2) | 2));
		stream_q.push_back(8'($urandom));
		stream_q.push_back(8'($urandom));
	endtask

	////////////////////////////////////////
	// reference model

	// walks the tokens one after another from the end of the length varint
	task automatic parse_tokens(int from, int upto);
		int pos;
		preparser_pkg::byte_t b;
		pos = from;
		tok_start.delete();
		tok_hdr.delete();
		tok_pay.delete();
		tok_copy.delete();
		while (pos < upto) begin
			b = get_byte(pos);
			tok_start.push_back(pos);
			if (b[1:0] == 2'b01) begin
				tok_hdr.push_back(2);
				tok_pay.push_back(0);
				tok_copy.push_back(int'(b[4:2]) + 4);
			end else if (b[1:0] == 2'b10) begin
				tok_hdr.push_back(3);
				tok_pay.push_back(0);
				tok_copy.push_back(int'(b[7:2]) + 1);
			end else if (b[7:2] == 6'd60) begin
				tok_hdr.push_back(2);
				tok_pay.push_back(int'(get_byte(pos + 1)) + 1);
				tok_copy.push_back(-1);
			end else if (b[7:2] == 6'd61) begin
				tok_hdr.push_back(3);
				tok_pay.push_back(int'({get_byte(pos + 2), get_byte(pos + 1)}) + 1);
				tok_copy.push_back(-1);
			end else begin
				tok_hdr.push_back(1);
				tok_pay.push_back(int'(b[7:2]) + 1);
				tok_copy.push_back(-1);
			end
			pos = tok_start[$] + tok_hdr[$] + tok_pay[$];
		end
	endtask

	task automatic build_expected();
		int nb, rem, h, base, skip, owed, lit, sum, t, hend, tend, j, room, clip;
		preparser_pkg::pos_mask_t   mask;
		preparser_pkg::slice_data_t sd;
		preparser_pkg::addr_t       run;
		nb  = (stream_q.size() + 15) / 16;
		rem = stream_q.size() % 16;
		h   = 1;
		while (h < preparser_pkg::MAX_HDR && get_byte(h - 1) >= 8'h80)
			h++;	// top bit set continues the varint
		parse_tokens(h, nb * 16);
		exp_q.delete();
		run = '0;
		for (int k = 0; k < nb; k++) begin
			base = 16 * k;
			skip = h;
			owed = 0;
			if (k != 0) begin	// the token running into this slice
				t = 0;
				foreach (tok_start[i])
					if (tok_start[i] < base)
						t = i;
				hend = tok_start[t] + tok_hdr[t];
				tend = hend + tok_pay[t];
				skip = (hend > base) ? hend - base : 0;
				owed = (tend > base + skip) ? tend - base - skip : 0;
			end
			lit  = (owed < 16 - skip) ? owed : 16 - skip;
			sum  = lit;
			mask = '0;
			foreach (tok_start[i]) begin
				j = tok_start[i] - base;
				if (j >= 0 && j < 16 && !(k == nb - 1 && rem != 0 && j >= rem)) begin
					mask[15 - j] = 1'b1;
					room = (16 - j - tok_hdr[i] > 0) ? 16 - j - tok_hdr[i] : 0;
					clip = (tok_pay[i] < room) ? tok_pay[i] : room;
					sum += (tok_copy[i] >= 0) ? tok_copy[i] : clip;
				end
			end
			for (int i = 0; i < preparser_pkg::SLICE_BYTES; i++)
				sd[143 - 8 * i -: 8] = get_byte(base + i);	// zeros past the last beat
			if (owed != 0 || mask != '0)
				exp_q.push_back('{data: sd << (8 * skip), token_pos: mask << skip,
					address: run, start_lit: owed != 0,
					garbage_cnt: preparser_pkg::garbage_t'(skip)});
			run = run + preparser_pkg::addr_t'(sum);
		end
	endtask

	////////////////////////////////////////
	// stimulus

	task automatic run_stream();
		int nb;
		preparser_pkg::beat_t beat;
		build_expected();
		got_q.delete();
		nb = (stream_q.size() + 15) / 16;
		@(negedge clk);
		start      = 1'b1;
		stream_len = preparser_pkg::addr_t'(stream_q.size());
		@(negedge clk);
		start = 1'b0;
		check_done(stream_done, 1'b0, "stream_done after start");
		for (int b = 0; b < nb; b++) begin
			for (int i = 0; i < preparser_pkg::BEAT_BYTES; i++)
				beat[127 - 8 * i -: 8] = get_byte(16 * b + i);
			if (b != 0)
				@(negedge clk);
			data     = beat;
			in_valid = 1'b1;
			do @(posedge clk); while (!in_ready);	// beat taken on this edge
		end
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		check_done(stream_done, 1'b1, "stream_done");	// last slice is past the slicer by now
		repeat (6) @(negedge clk);	// room for any stray slice
	endtask

	task automatic test_short_literals();
		stream_q = {8'h8c, 8'h01};
		add_lit(3, 0);
		add_lit(4, 0);
		add_lit(3, 0);
		run_stream();
		need_slices(1);
		if (got_q.size() >= 1) begin
			check_count(got_q[0].garbage_cnt, 3'd2, "garbage_cnt");
			check_mask(got_q[0].token_pos, 16'h8840, "token_pos");
			check_addr(got_q[0].address, '0, "address");
			check_done(got_q[0].start_lit, 1'b0, "start_lit");
		end
	endtask

	task automatic test_copies_across_boundary();
		stream_q = {8'h40};
		add_lit(12, 0);
		add_copy2(8);	// bytes 14 to 16
		add_lit(13, 0);
		add_copy1(4);	// bytes 31 and 32
		add_lit(4, 0);
		run_stream();
		need_slices(3);
		if (got_q.size() >= 3) begin
			check_count(got_q[1].garbage_cnt, 3'd1, "slice 1 garbage_cnt");
			check_addr(got_q[1].address, got_q[0].address + 24'd20, "slice 1 address");
			check_count(got_q[2].garbage_cnt, 3'd1, "slice 2 garbage_cnt");
		end
	endtask

	task automatic test_long_literal();
		stream_q = {8'h28};
		add_lit(40, 2);
		add_lit(2, 0);
		run_stream();
		need_slices(3);
		if (got_q.size() >= 3) begin
			check_done(got_q[1].start_lit, 1'b1, "slice 1 start_lit");
			check_mask(got_q[1].token_pos, '0, "slice 1 token_pos");
			check_addr(got_q[2].address, got_q[1].address + 24'd16, "slice 2 address");
		end
	endtask

	task automatic test_tail_mask();
		stream_q = {8'h20};
		add_lit(29, 0);
		add_copy2(4);	// ends at byte 33, last slice holds only its tail
		run_stream();
		if (got_q.size() != 2) begin
			err_cnt++;
			$display("empty final slice was not dropped, %0d slices arrived", got_q.size());
		end
	endtask

	task automatic test_backpressure();
		stream_q = {8'h95, 8'h03};
		while (stream_q.size() < 140) begin
			case ($urandom % 5)
				0: add_lit(1 + $urandom % 20, 0);
				1: add_lit(20 + $urandom % 21, 1);
				2: add_lit(3 + $urandom % 10, 2);
				3: add_copy1(4 + $urandom % 8);
				default: add_copy2(1 + $urandom % 64);
			endcase
		end
		rand_ready = 1'b1;
		run_stream();
		rand_ready = 1'b0;
	endtask

	////////////////////////////////////////
	// output side and watchdog

	always @(negedge clk)
		out_ready = rand_ready ? 1'($urandom % 2) : 1'b1;

	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			got_q.push_back(slice_out);
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("slice arrived at %0t when none was expected", $time);
			end else
				check_slice(slice_out, exp_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("run stopped after %0d cycles with %0d slices pending", cycles, exp_q.size());
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hfead));
		clk        = 1'b0;
		rst_n      = 1'b0;
		start      = 1'b0;
		stream_len = '0;
		data       = '0;
		in_valid   = 1'b0;
		out_ready  = 1'b1;
		rand_ready = 1'b0;
		err_cnt    = 0;
		chk_cnt    = 0;
		cycles     = 0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		test_short_literals();
		test_copies_across_boundary();
		test_long_literal();
		test_tail_mask();
		test_backpressure();
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verification/preparser_properties.sv */
/*
 * slicer handshake properties
 * reset values, payload hold under back-pressure, start legality
 */
`timescale 1ns/1ps

module preparser_properties (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  start,
	input logic                  stream_done,
	input logic                  in_ready,
	input logic                  slice_valid,
	input logic                  slice_ready,
	input preparser_pkg::slice_t slice
);

	// registers take their reset value on the edge that samples rst_n low
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !in_ready && !slice_valid)
		else $error("in_ready or slice_valid high after reset");

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		slice_valid && !slice_ready |=> slice_valid && $stable(slice))
		else $error("slice payload changed while stalled");

	a_start_legal: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> stream_done)
		else $error("start while a stream is in flight");

endmodule

bind beat_slicer preparser_properties props_i (.*);

/* verilog/preparser.sv */
/*
 * snappy stream preparser top
 * slicer, speculator, chainer and accountant in a valid/ready pipeline
 */
`timescale 1ns/1ps

module preparser (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  preparser_pkg::addr_t       stream_len,
	input  preparser_pkg::beat_t       data,
	input  logic                       in_valid,
	output logic                       in_ready,
	output preparser_pkg::out_slice_t  slice_out,
	output logic                       out_valid,
	input  logic                       out_ready,
	output logic                       stream_done
);

	preparser_pkg::slice_t s1;	// slicer to speculator
	preparser_pkg::spec_t  s2;	// speculator to chainer
	preparser_pkg::chain_t s3;	// chainer to accountant
	logic s1_valid, s1_ready;
	logic s2_valid, s2_ready;
	logic s3_valid, s3_ready;

	beat_slicer slicer_i (
		.clk(clk), .rst_n(rst_n), .start(start), .stream_len(stream_len),
		.data(data), .in_valid(in_valid), .in_ready(in_ready),
		.slice(s1), .slice_valid(s1_valid), .slice_ready(s1_ready),
		.stream_done(stream_done)
	);

	token_speculator spec_i (
		.clk(clk), .rst_n(rst_n), .slice_in(s1), .in_valid(s1_valid),
		.in_ready(s1_ready), .spec_out(s2), .out_valid(s2_valid), .out_ready(s2_ready)
	);

	token_chainer chain_i (
		.clk(clk), .rst_n(rst_n), .spec_in(s2), .in_valid(s2_valid),
		.in_ready(s2_ready), .chain_out(s3), .out_valid(s3_valid), .out_ready(s3_ready)
	);

	slice_accountant acct_i (
		.clk(clk), .rst_n(rst_n), .chain_in(s3), .in_valid(s3_valid),
		.in_ready(s3_ready), .slice_out(slice_out), .out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

/* verilog/slice_accountant.sv */
/*
 * slice accountant, stage 4
 * masks the tail, sums the slice output length into the running address,
 * shifts out leading garbage and drops slices with nothing to parse
 */
`timescale 1ns/1ps

module slice_accountant (
	input  logic                       clk,
	input  logic                       rst_n,
	input  preparser_pkg::chain_t      chain_in,
	input  logic                       in_valid,
	output logic                       in_ready,
	output preparser_pkg::out_slice_t  slice_out,
	output logic                       out_valid,
	input  logic                       out_ready
);

	preparser_pkg::pos_mask_t tok;	// real starts inside the stream
	preparser_pkg::addr_t     sum;	// output bytes this slice adds
	preparser_pkg::addr_t     base;	// address where this slice starts
	preparser_pkg::addr_t     run_q;
	logic                     keep;

	always_comb begin
		tok = chain_in.token_pos & chain_in.slice.tail_mask;
		sum = preparser_pkg::addr_t'(chain_in.lit_bytes);
		for (int j = 0; j < preparser_pkg::BEAT_BYTES; j++) begin
			if (tok[15-j])
				sum = sum + preparser_pkg::addr_t'(chain_in.tok_len[j]);
		end
		base = chain_in.slice.first ? '0 : run_q;
		keep = chain_in.start_lit || (tok != '0);
	end

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			run_q     <= '0;
		end else if (in_ready) begin
			out_valid <= in_valid && keep;	// empty slices vanish here
			if (in_valid)
				run_q <= base + sum;	// dropped slices add zero
		end
	end

	// lead_skip is zero whenever a literal continues from byte 0,
	// except a literal header that spilled over, which is garbage too
	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			slice_out <= '{data: chain_in.slice.data << (8 * chain_in.lead_skip),
				token_pos: tok << chain_in.lead_skip, address: base,
				start_lit: chain_in.start_lit, garbage_cnt: chain_in.lead_skip};
	end

endmodule

/* verilog/token_chainer.sv */
/*
 * token chainer, stage 3
 * follows the speculative next-start masks from the first real start
 * and carries owed literal bytes and spilled token bytes between slices
 */
`timescale 1ns/1ps

module token_chainer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  preparser_pkg::spec_t   spec_in,
	input  logic                   in_valid,
	output logic                   in_ready,
	output preparser_pkg::chain_t  chain_out,
	output logic                   out_valid,
	input  logic                   out_ready
);

	preparser_pkg::lit_len_t   owed_q;	// literal payload still owed
	preparser_pkg::lit_len_t   owed_n;
	preparser_pkg::lit_len_t   eff_owed;
	preparser_pkg::lit_len_t   over;
	preparser_pkg::garbage_t   skip_q;	// spilled header or copy bytes
	preparser_pkg::garbage_t   skip_n;
	preparser_pkg::garbage_t   eff_skip;
	preparser_pkg::garbage_t   spill;
	preparser_pkg::pos_mask_t  walk;
	preparser_pkg::look_mask_t look;	// start bits for bytes 16 and 17
	preparser_pkg::tok_len_t   lit_bytes;
	preparser_pkg::tok_len_t [0:preparser_pkg::BEAT_BYTES-1] sel_len;
	preparser_pkg::byte_t      tag14;
	preparser_pkg::byte_t      tag15;
	logic [17:0] reach;	// first byte not owed to an earlier token
	logic        all_lit;
	logic        load;

	assign tag14 = spec_in.slice.data[31:24];
	assign tag15 = spec_in.slice.data[23:16];
	assign load  = in_valid && in_ready;

	always_comb begin
		eff_skip = spec_in.slice.first ? spec_in.hdr_len : skip_q;	// new stream drops carry
		eff_owed = spec_in.slice.first ? '0 : owed_q;
		reach    = 18'(eff_skip) + 18'(eff_owed);
		all_lit  = reach >= 18'd16;
		walk     = '0;
		look     = '0;
		over     = '0;
		if (!all_lit)
			walk = 16'h8000 >> reach[3:0];

		// each real start pulls in the start that follows it
		for (int j = 0; j < preparser_pkg::BEAT_BYTES; j++) begin
			sel_len[j] = '0;
			if (walk[15-j]) begin
				walk       = walk | spec_in.next_mask[j];
				look       = look | spec_in.next_look[j];
				over       = over | spec_in.lit_over[j];	// only the last token overflows
				sel_len[j] = spec_in.tok_len[j];
			end
		end

		// literal header bytes past byte 15
		spill = '0;
		if (walk[0])
			spill = (tag15 == 8'hf0) ? 3'd1 : (tag15 == 8'hf4) ? 3'd2 : 3'd0;
		else if (walk[1])
			spill = (tag14 == 8'hf4) ? 3'd1 : 3'd0;

		if (all_lit) begin	// slice lies wholly inside one literal
			owed_n    = 17'(reach - 18'd16);
			skip_n    = '0;
			lit_bytes = 9'(18'd16 - 18'(eff_skip));
		end else begin
			owed_n    = over;
			lit_bytes = 9'(eff_owed);
			if (over != '0)
				skip_n = spill;
			else	// last token ends at 16, 17 or, for a copy at 15, 18
				skip_n = look[1] ? 3'd0 : (look[0] ? 3'd1 : 3'd2);
		end
	end

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			owed_q    <= '0;
			skip_q    <= '0;
		end else begin
			if (in_ready)
				out_valid <= in_valid;
			if (load) begin
				owed_q <= owed_n;
				skip_q <= skip_n;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			chain_out <= '{slice: spec_in.slice, token_pos: walk,
				start_lit: eff_owed != '0, lit_bytes: lit_bytes,
				tok_len: sel_len, lead_skip: eff_skip};
	end

endmodule

/* verilog/token_speculator.sv */
/*
 * token speculator, stage 2
 * decodes a token at every main byte in parallel and counts the
 * length varint bytes at the head of the first slice
 */
`timescale 1ns/1ps

module token_speculator (
	input  logic                   clk,
	input  logic                   rst_n,
	input  preparser_pkg::slice_t  slice_in,
	input  logic                   in_valid,
	output logic                   in_ready,
	output preparser_pkg::spec_t   spec_out,
	output logic                   out_valid,
	input  logic                   out_ready
);

	preparser_pkg::pos_mask_t  nxt_mask [preparser_pkg::BEAT_BYTES];
	preparser_pkg::look_mask_t nxt_look [preparser_pkg::BEAT_BYTES];
	preparser_pkg::tok_len_t   len      [preparser_pkg::BEAT_BYTES];
	preparser_pkg::lit_len_t   over     [preparser_pkg::BEAT_BYTES];
	preparser_pkg::garbage_t   hdr_cnt;
	logic                      cont;	// still inside the varint

	for (genvar i = 0; i < preparser_pkg::BEAT_BYTES; i++) begin : g_dec
		tag_decoder dec_i (
			.tag_bytes  (slice_in.data[143-8*i -: 24]),
			.bytes_left (5'(preparser_pkg::BEAT_BYTES - i)),
			.next_mask  (nxt_mask[i]),
			.next_look  (nxt_look[i]),
			.tok_len    (len[i]),
			.lit_over   (over[i])
		);
	end

	// varint bytes with the top bit set continue the length
	always_comb begin
		hdr_cnt = 3'd1;
		cont    = 1'b1;
		for (int k = 0; k < preparser_pkg::MAX_HDR - 1; k++) begin
			if (cont && slice_in.data[143-8*k])
				hdr_cnt = 3'(k + 2);
			else
				cont = 1'b0;
		end
	end

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			spec_out.slice   <= slice_in;
			spec_out.hdr_len <= slice_in.first ? hdr_cnt : '0;
			for (int j = 0; j < preparser_pkg::BEAT_BYTES; j++) begin
				spec_out.next_mask[j] <= nxt_mask[j];
				spec_out.next_look[j] <= nxt_look[j];
				spec_out.tok_len[j]   <= len[j];
				spec_out.lit_over[j]  <= over[j];
			end
		end
	end

endmodule

/* verilog/beat_slicer.sv */
/*
 * beat slicer, stage 1
 * buffers one beat and pairs it with 2 bytes of the next beat,
 * counts beats against the stream length and flushes the last slice
 */
`timescale 1ns/1ps

module beat_slicer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  preparser_pkg::addr_t   stream_len,
	input  preparser_pkg::beat_t   data,
	input  logic                   in_valid,
	output logic                   in_ready,
	output preparser_pkg::slice_t  slice,
	output logic                   slice_valid,
	input  logic                   slice_ready,
	output logic                   stream_done
);

	preparser_pkg::slicer_state_t state;
	preparser_pkg::beat_t         hold;	// beat waiting for its lookahead
	preparser_pkg::pos_mask_t     tail_q;
	preparser_pkg::addr_t         len_m1;
	logic [19:0] beat_cnt;	// beats accepted so far
	logic [19:0] beat_last;	// index of the final beat
	logic        first_pend;	// next slice out is the first one
	logic        slot_free;
	logic        accept;

	assign len_m1    = stream_len - 1'b1;
	assign slot_free = !slice_valid || slice_ready;
	assign in_ready  = (state == preparser_pkg::COLLECT) && slot_free;
	assign accept    = in_valid && in_ready;

	////////////////////////////////////////
	// control

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= preparser_pkg::IDLE;
			slice_valid <= 1'b0;
			stream_done <= 1'b1;
			beat_cnt    <= '0;
			first_pend  <= 1'b0;
		end else begin
			if (slice_valid && slice_ready) begin
				slice_valid <= 1'b0;
				if (slice.last)
					stream_done <= 1'b1;	// last slice handed on
			end
			case (state)
				preparser_pkg::IDLE: begin
					if (start) begin
						state       <= preparser_pkg::COLLECT;
						beat_cnt    <= '0;
						first_pend  <= 1'b1;
						stream_done <= 1'b0;
					end
				end
				preparser_pkg::COLLECT: begin
					if (accept) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt != '0) begin	// held beat gets its lookahead
							slice_valid <= 1'b1;
							first_pend  <= 1'b0;
						end
						if (beat_cnt == beat_last)
							state <= preparser_pkg::FLUSH;
					end
				end
				preparser_pkg::FLUSH: begin
					if (slot_free) begin	// held beat leaves with zero lookahead
						slice_valid <= 1'b1;
						first_pend  <= 1'b0;
						state       <= preparser_pkg::IDLE;
					end
				end
				default: state <= preparser_pkg::IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// payload

	always_ff @(posedge clk) begin
		if (state == preparser_pkg::IDLE && start) begin
			beat_last <= len_m1[23:4];	// ceil(len/16) minus one
			tail_q    <= (stream_len[3:0] == 4'd0) ? '1 : ~(16'hffff >> stream_len[3:0]);
		end
		if (accept) begin
			hold <= data;
			if (beat_cnt != '0)
				slice <= '{data: {hold, data[127 -: preparser_pkg::LOOK_BYTES*8]},
					first: first_pend, last: 1'b0, tail_mask: '1};
		end
		if (state == preparser_pkg::FLUSH && slot_free)
			slice <= '{data: {hold, {preparser_pkg::LOOK_BYTES{8'h00}}},
				first: first_pend, last: 1'b1, tail_mask: tail_q};
	end

endmodule

/* verilog/tag_decoder.sv */
/*
 * snappy tag decoder
 * assumes a token starts at its byte and decodes where the next token
 * starts, the output bytes added inside the slice and literal overflow
 */
`timescale 1ns/1ps

module tag_decoder (
	input  preparser_pkg::byte_t [0:2] tag_bytes,	// tag first, then two following bytes
	input  logic [4:0]                 bytes_left,	// main bytes from this one to slice end
	output preparser_pkg::pos_mask_t   next_mask,
	output preparser_pkg::look_mask_t  next_look,
	output preparser_pkg::tok_len_t    tok_len,
	output preparser_pkg::lit_len_t    lit_over
);

	logic [17:0] hdr;	// tag plus extension bytes, or whole copy
	logic [17:0] pay;	// literal payload length
	logic [17:0] nxt;	// next start counted from slice byte 0
	logic [17:0] room;
	logic [17:0] in_slice;
	logic [8:0]  copy_len;
	logic        is_copy;

	always_comb begin
		is_copy  = 1'b0;
		copy_len = '0;
		hdr      = 18'd1;
		pay      = 18'({tag_bytes[0][7:2]}) + 18'd1;	// inline literal length
		case (tag_bytes[0][1:0])
			2'b01: begin	// copy with 1 byte offset
				is_copy  = 1'b1;
				hdr      = 18'd2;
				pay      = '0;
				copy_len = 9'(tag_bytes[0][4:2]) + 9'd4;
			end
			2'b10: begin	// copy with 2 byte offset
				is_copy  = 1'b1;
				hdr      = 18'd3;
				pay      = '0;
				copy_len = 9'(tag_bytes[0][7:2]) + 9'd1;
			end
			default: begin
				if (tag_bytes[0][7:2] == 6'd60) begin
					hdr = 18'd2;
					pay = 18'(tag_bytes[1]) + 18'd1;
				end else if (tag_bytes[0][7:2] == 6'd61) begin
					hdr = 18'd3;
					pay = 18'({tag_bytes[2], tag_bytes[1]}) + 18'd1;	// little endian
				end
			end
		endcase

		nxt  = (18'd16 - 18'(bytes_left)) + hdr + pay;
		room = (18'(bytes_left) > hdr) ? 18'(bytes_left) - hdr : '0;
		in_slice = (pay < room) ? pay : room;	// payload clipped to the main bytes

		next_mask = (nxt < 18'd16) ? (16'h8000 >> nxt[3:0]) : '0;
		next_look = {nxt == 18'd16, nxt == 18'd17};
		tok_len   = is_copy ? copy_len : in_slice[8:0];
		lit_over  = 17'(pay - in_slice);	// zero for copies
	end

endmodule

/* verilog/preparser_pkg.sv */
/*
 * snappy preparser shared definitions
 * widths, payload types and the structs passed between the four stages
 */
package preparser_pkg;

	localparam int BEAT_BYTES  = 16;	// bytes per input beat
	localparam int LOOK_BYTES  = 2;	// lookahead bytes borrowed from the next beat
	localparam int SLICE_BYTES = BEAT_BYTES + LOOK_BYTES;
	localparam int ADDR_W      = 24;	// decompressed address width
	localparam int MAX_HDR     = 5;	// longest length varint at stream start

	typedef logic [7:0]                 byte_t;
	typedef logic [BEAT_BYTES*8-1:0]    beat_t;
	typedef logic [SLICE_BYTES*8-1:0]   slice_data_t;	// byte 0 in the top bits
	typedef logic [BEAT_BYTES-1:0]      pos_mask_t;	// msb is byte 0
	typedef logic [LOOK_BYTES-1:0]      look_mask_t;	// msb is byte 16
	typedef logic [8:0]                 tok_len_t;
	typedef logic [16:0]                lit_len_t;
	typedef logic [ADDR_W-1:0]          addr_t;
	typedef logic [2:0]                 garbage_t;

	typedef enum logic [1:0] {IDLE, COLLECT, FLUSH} slicer_state_t;

	////////////////////////////////////////
	// stage payloads

	typedef struct packed {
		slice_data_t data;
		logic        first;	// first slice of the stream
		logic        last;	// flushed slice, no lookahead
		pos_mask_t   tail_mask;	// clears bytes past the stream end
	} slice_t;

	typedef struct packed {
		slice_t                            slice;
		pos_mask_t  [0:BEAT_BYTES-1]       next_mask;	// one-hot next start per byte
		look_mask_t [0:BEAT_BYTES-1]       next_look;
		tok_len_t   [0:BEAT_BYTES-1]       tok_len;
		lit_len_t   [0:BEAT_BYTES-1]       lit_over;
		garbage_t                          hdr_len;	// varint bytes, first slice only
	} spec_t;

	typedef struct packed {
		slice_t                      slice;
		pos_mask_t                   token_pos;
		logic                        start_lit;
		tok_len_t                    lit_bytes;	// carried literal payload in this slice
		tok_len_t  [0:BEAT_BYTES-1]  tok_len;	// zero where no real token starts
		garbage_t                    lead_skip;
	} chain_t;

	typedef struct packed {
		slice_data_t data;
		pos_mask_t   token_pos;
		addr_t       address;
		logic        start_lit;
		garbage_t    garbage_cnt;
	} out_slice_t;

endpackage
